// ==== tests/muldiv_golden.txt ====
# op dest dest_valid a b rob_slot a_fwd a_fwd_slot b_fwd b_fwd_slot exp_result exp_dest_valid
# all hex; op 1 MULT 2 MULTU 3 DIV 4 DIVU 5 MFHI 6 MFLO 7 MTHI 8 MTLO
1 01 1 fffffffd 00000007 0 0 0 0 0 ffffffeb 0
5 03 1 00000000 00000000 1 0 0 0 0 ffffffff 1
6 04 1 00000000 00000000 2 0 0 0 0 ffffffeb 1
2 02 1 ffffffff ffffffff 3 0 0 0 0 00000001 0
5 05 1 00000000 00000000 4 0 0 0 0 fffffffe 1
6 06 1 00000000 00000000 5 0 0 0 0 00000001 1
3 07 1 fffffff9 00000002 6 0 0 0 0 fffffffd 0
5 08 1 00000000 00000000 7 0 0 0 0 ffffffff 1
4 09 1 00000064 00000007 8 0 0 0 0 0000000e 0
5 0a 1 00000000 00000000 9 0 0 0 0 00000002 1
3 0b 1 00000011 fffffffb a 0 0 0 0 fffffffd 0
5 0c 1 00000000 00000000 b 0 0 0 0 00000002 1
4 0d 1 12345678 00000000 c 0 0 0 0 ffffffff 0
5 0e 1 00000000 00000000 d 0 0 0 0 12345678 1
7 0f 1 cafef00d 00000000 e 0 0 0 0 ffffffff 0
8 10 1 0badc0de 00000000 f 0 0 0 0 ffffffff 0
5 11 1 00000000 00000000 0 0 0 0 0 cafef00d 1
6 12 1 00000000 00000000 1 0 0 0 0 0badc0de 1
7 13 1 deadbeef 00000000 2 1 d 0 0 0badc0de 0
5 14 1 00000000 00000000 3 0 0 0 0 12345678 1
2 15 1 11111111 22222222 4 1 9 1 8 0000001c 0
5 16 1 00000000 00000000 5 0 0 0 0 00000000 1
3 17 1 ffffff9c 00000001 6 0 0 1 4 fffffffd 0
5 18 1 00000000 00000000 7 0 0 0 0 fffffff0 1

// ==== flist.f ====
src/muldiv_pkg.sv
src/muldiv_unit.sv
src/ex_mul_wrapper.sv
src/rob_result_file.sv
src/muldiv_subsystem.sv
tests/muldiv_assertions.sv
tests/muldiv_tb.sv

// ==== tests/muldiv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
  import muldiv_pkg::*;

  localparam int ROB_DEPTHLOG2 = 4;
  localparam int MAX_LINES     = 64;
  localparam int SEED          = 59932;

  typedef logic [ROB_DEPTHLOG2-1:0] slot_t;

  logic       clock;
  logic       reset_n;
  logic       inst_valid;
  muldiv_op_t op;
  reg_idx_t   dest;
  logic       dest_valid;
  word_t      a;
  word_t      b;
  slot_t      slot;
  logic       a_fwd;
  slot_t      a_fwd_slot;
  logic       b_fwd;
  slot_t      b_fwd_slot;
  logic       ready;
  logic       wb_valid;
  slot_t      wb_idx;
  word_t      wb_result;
  reg_idx_t   wb_dest;
  logic       wb_dest_valid;

  // Golden operations and their expected writebacks
  muldiv_op_t g_op     [MAX_LINES];
  reg_idx_t   g_dest   [MAX_LINES];
  logic       g_dv     [MAX_LINES];
  word_t      g_a      [MAX_LINES];
  word_t      g_b      [MAX_LINES];
  slot_t      g_slot   [MAX_LINES];
  logic       g_af     [MAX_LINES];
  slot_t      g_afs    [MAX_LINES];
  logic       g_bf     [MAX_LINES];
  slot_t      g_bfs    [MAX_LINES];
  word_t      g_res    [MAX_LINES];
  logic       g_edv    [MAX_LINES];

  int   n_lines;
  int   wb_count;
  int   cycle_limit;
  logic long_pending;

  muldiv_subsystem #(
    .ROB_DEPTHLOG2 (ROB_DEPTHLOG2)
  ) UUT (
    .clock               (clock),
    .reset_n             (reset_n),
    .inst_valid_i        (inst_valid),
    .op_i                (op),
    .dest_reg_i          (dest),
    .dest_valid_i        (dest_valid),
    .a_i                 (a),
    .b_i                 (b),
    .rob_slot_i          (slot),
    .a_fwd_i             (a_fwd),
    .a_fwd_slot_i        (a_fwd_slot),
    .b_fwd_i             (b_fwd),
    .b_fwd_slot_i        (b_fwd_slot),
    .ready_o             (ready),
    .rob_wb_valid_o      (wb_valid),
    .rob_wb_idx_o        (wb_idx),
    .rob_wb_result_o     (wb_result),
    .rob_wb_dest_o       (wb_dest),
    .rob_wb_dest_valid_o (wb_dest_valid)
  );

  bind ex_mul_wrapper muldiv_assertions u_muldiv_assertions (
    .clock      (clock),
    .reset_n    (reset_n),
    .ready_i    (ready_o),
    .wb_valid_i (rob_wb_valid_o),
    .op_i       (unit_op),
    .state_i    (u_muldiv_unit.state)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ====================
  // Error handling and compare tasks
  // ====================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_slot(input string name, input slot_t got, input slot_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ====================
  // Golden file
  // ====================

  task automatic load_golden();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] f [12];
    fd = $fopen("tests/muldiv_golden.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open tests/muldiv_golden.txt");
    end
    n_lines = 0;
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                     f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (rc == 12 && n_lines < MAX_LINES) begin
          g_op[n_lines]   = muldiv_op_t'(f[0][3:0]);
          g_dest[n_lines] = f[1][4:0];
          g_dv[n_lines]   = f[2][0];
          g_a[n_lines]    = f[3];
          g_b[n_lines]    = f[4];
          g_slot[n_lines] = f[5][ROB_DEPTHLOG2-1:0];
          g_af[n_lines]   = f[6][0];
          g_afs[n_lines]  = f[7][ROB_DEPTHLOG2-1:0];
          g_bf[n_lines]   = f[8][0];
          g_bfs[n_lines]  = f[9][ROB_DEPTHLOG2-1:0];
          g_res[n_lines]  = f[10];
          g_edv[n_lines]  = f[11][0];
          n_lines++;
        end else if (rc > 0) begin
          abort_run("A golden line could not be read or does not fit the table");
        end
      end
    end
    $fclose(fd);
    if (n_lines == 0) begin
      abort_run("The golden file holds no operations");
    end
  endtask

  task automatic drive_line(input int i);
    inst_valid = 1'b1;
    op         = g_op[i];
    dest       = g_dest[i];
    dest_valid = g_dv[i];
    a          = g_a[i];
    b          = g_b[i];
    slot       = g_slot[i];
    a_fwd      = g_af[i];
    a_fwd_slot = g_afs[i];
    b_fwd      = g_bf[i];
    b_fwd_slot = g_bfs[i];
  endtask

  // ====================
  // Stimulus
  // ====================

  initial begin
    int gap;
    int dummy;
    dummy        = $urandom(SEED);
    reset_n      = 1'b0;
    inst_valid   = 1'b0;
    op           = OP_NONE;
    dest         = '0;
    dest_valid   = 1'b0;
    a            = '0;
    b            = '0;
    slot         = '0;
    a_fwd        = 1'b0;
    a_fwd_slot   = '0;
    b_fwd        = 1'b0;
    b_fwd_slot   = '0;
    long_pending = 1'b0;
    wb_count     = 0;
    load_golden();
    cycle_limit = n_lines * 40 + 20;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      gap = $urandom_range(3);
      repeat (gap) @(negedge clock);
      drive_line(i);
      // Held while a long operation stalls the lane
      while (!ready) @(negedge clock);
      @(posedge clock);
      if (g_op[i] inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU}) begin
        long_pending = 1'b1;
      end
      @(negedge clock);
      inst_valid = 1'b0;
    end
    wait (wb_count == n_lines);
    repeat (8) @(negedge clock);
    if (wb_count == n_lines && !long_pending) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run($sformatf("Saw %0d writebacks for %0d golden lines", wb_count, n_lines));
    end
  end

  // Writebacks come back in issue order, one per golden line
  initial begin
    wait (reset_n === 1'b1);
    forever begin
      @(negedge clock);
      if (long_pending && ready && !wb_valid) begin
        abort_run("ready_o went high before the long operation wrote back");
      end
      if (wb_valid) begin
        if (wb_count >= n_lines) begin
          abort_run("A writeback arrived with no golden line left");
        end
        check_slot("rob_wb_idx_o", wb_idx, g_slot[wb_count]);
        check_word("rob_wb_result_o", wb_result, g_res[wb_count]);
        check_reg("rob_wb_dest_o", wb_dest, g_dest[wb_count]);
        check_bit("rob_wb_dest_valid_o", wb_dest_valid, g_edv[wb_count]);
        long_pending = 1'b0;
        wb_count++;
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    forever begin
      @(posedge clock);
      cycles++;
      if (cycles > cycle_limit) begin
        abort_run($sformatf("Timeout after %0d cycles with %0d of %0d writebacks seen",
                            cycles, wb_count, n_lines));
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/muldiv_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_assertions (
  input  wire                          clock,
  input  wire                          reset_n,
  input  wire                          ready_i,
  input  wire                          wb_valid_i,
  input  wire muldiv_pkg::muldiv_op_t  op_i,
  input  wire muldiv_pkg::mdu_state_t  state_i
);
  import muldiv_pkg::*;

  logic long_start;

  // A MULT or DIV entering the idle unit
  assign long_start = (state_i == IDLE) &&
                      (op_i inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU});

  // Ready stays low through all 32 iterations and the writeback comes as it returns
  no_wb_while_stalled: assert property (
    @(posedge clock) disable iff (!reset_n)
      long_start |=> (!wb_valid_i && !ready_i)[*32] ##1 (wb_valid_i && ready_i)
  ) else $error("Writeback while ready is low or missing when the stall ends");

  back_to_idle: assert property (
    @(posedge clock) disable iff (!reset_n) long_start |-> ##[1:34] (state_i == IDLE)
  ) else $error("Unit did not return to IDLE within 34 cycles");

  wb_valid_known: assert property (
    @(posedge clock) disable iff (!reset_n) !$isunknown(wb_valid_i)
  ) else $error("Writeback valid is unknown after reset");

endmodule

`default_nettype wire

// ==== src/muldiv_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_subsystem #(
  parameter int ROB_DEPTHLOG2 = 4
) (
  input  wire                          clock,
  input  wire                          reset_n,

  input  wire                          inst_valid_i,
  input  wire muldiv_pkg::muldiv_op_t  op_i,
  input  wire muldiv_pkg::reg_idx_t    dest_reg_i,
  input  wire                          dest_valid_i,
  input  wire muldiv_pkg::word_t       a_i,
  input  wire muldiv_pkg::word_t       b_i,
  input  wire [ROB_DEPTHLOG2-1:0]      rob_slot_i,
  input  wire                          a_fwd_i,
  input  wire [ROB_DEPTHLOG2-1:0]      a_fwd_slot_i,
  input  wire                          b_fwd_i,
  input  wire [ROB_DEPTHLOG2-1:0]      b_fwd_slot_i,
  output logic                         ready_o,

  output logic                         rob_wb_valid_o,
  output logic [ROB_DEPTHLOG2-1:0]     rob_wb_idx_o,
  output muldiv_pkg::word_t            rob_wb_result_o,
  output muldiv_pkg::reg_idx_t         rob_wb_dest_o,
  output logic                         rob_wb_dest_valid_o
);
  import muldiv_pkg::*;

  // Forwarding lookup between the lane and the result storage
  logic [ROB_DEPTHLOG2-1:0] a_lookup_idx;
  logic [ROB_DEPTHLOG2-1:0] b_lookup_idx;
  word_t                    a_fwd_data;
  word_t                    b_fwd_data;

  ex_mul_wrapper #(
    .ROB_DEPTHLOG2 (ROB_DEPTHLOG2)
  ) u_ex_mul_wrapper (
    .clock               (clock),
    .reset_n             (reset_n),
    .inst_valid_i        (inst_valid_i),
    .op_i                (op_i),
    .dest_reg_i          (dest_reg_i),
    .dest_valid_i        (dest_valid_i),
    .a_i                 (a_i),
    .b_i                 (b_i),
    .rob_slot_i          (rob_slot_i),
    .a_fwd_i             (a_fwd_i),
    .a_fwd_slot_i        (a_fwd_slot_i),
    .b_fwd_i             (b_fwd_i),
    .b_fwd_slot_i        (b_fwd_slot_i),
    .ready_o             (ready_o),
    .a_lookup_idx_o      (a_lookup_idx),
    .b_lookup_idx_o      (b_lookup_idx),
    .a_fwd_data_i        (a_fwd_data),
    .b_fwd_data_i        (b_fwd_data),
    .rob_wb_valid_o      (rob_wb_valid_o),
    .rob_wb_idx_o        (rob_wb_idx_o),
    .rob_wb_result_o     (rob_wb_result_o),
    .rob_wb_dest_o       (rob_wb_dest_o),
    .rob_wb_dest_valid_o (rob_wb_dest_valid_o)
  );

  // Every writeback also lands in its ROB slot
  rob_result_file #(
    .ROB_DEPTHLOG2 (ROB_DEPTHLOG2)
  ) u_rob_result_file (
    .clock       (clock),
    .reset_n     (reset_n),
    .wr_en_i     (rob_wb_valid_o),
    .wr_idx_i    (rob_wb_idx_o),
    .wr_data_i   (rob_wb_result_o),
    .rd_a_idx_i  (a_lookup_idx),
    .rd_b_idx_i  (b_lookup_idx),
    .rd_a_data_o (a_fwd_data),
    .rd_b_data_o (b_fwd_data)
  );

endmodule

`default_nettype wire

// ==== src/rob_result_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_result_file #(
  parameter int ROB_DEPTHLOG2 = 4
) (
  input  wire                      clock,
  input  wire                      reset_n,

  // Writeback port
  input  wire                      wr_en_i,
  input  wire [ROB_DEPTHLOG2-1:0]  wr_idx_i,
  input  wire muldiv_pkg::word_t   wr_data_i,

  // Forwarding reads
  input  wire [ROB_DEPTHLOG2-1:0]  rd_a_idx_i,
  input  wire [ROB_DEPTHLOG2-1:0]  rd_b_idx_i,
  output muldiv_pkg::word_t        rd_a_data_o,
  output muldiv_pkg::word_t        rd_b_data_o
);
  import muldiv_pkg::*;

  localparam int ROB_DEPTH = 1 << ROB_DEPTHLOG2;

  // ====================
  // Slot storage
  // ====================

  word_t results [ROB_DEPTH];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < ROB_DEPTH; i++) begin
        results[i] <= '0;
      end
    end else if (wr_en_i) begin
      results[wr_idx_i] <= wr_data_i;
    end
  end

  // ====================
  // Read ports
  // ====================

  // Combinational, a write shows up after its edge
  assign rd_a_data_o = results[rd_a_idx_i];
  assign rd_b_data_o = results[rd_b_idx_i];

endmodule

`default_nettype wire

// ==== src/ex_mul_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mul_wrapper #(
  parameter int ROB_DEPTHLOG2 = 4
) (
  input  wire                          clock,
  input  wire                          reset_n,

  input  wire                          inst_valid_i,
  input  wire muldiv_pkg::muldiv_op_t  op_i,
  input  wire muldiv_pkg::reg_idx_t    dest_reg_i,
  input  wire                          dest_valid_i,
  input  wire muldiv_pkg::word_t       a_i,
  input  wire muldiv_pkg::word_t       b_i,
  input  wire [ROB_DEPTHLOG2-1:0]      rob_slot_i,
  input  wire                          a_fwd_i,
  input  wire [ROB_DEPTHLOG2-1:0]      a_fwd_slot_i,
  input  wire                          b_fwd_i,
  input  wire [ROB_DEPTHLOG2-1:0]      b_fwd_slot_i,
  output logic                         ready_o,

  output logic [ROB_DEPTHLOG2-1:0]     a_lookup_idx_o,
  output logic [ROB_DEPTHLOG2-1:0]     b_lookup_idx_o,
  input  wire muldiv_pkg::word_t       a_fwd_data_i,
  input  wire muldiv_pkg::word_t       b_fwd_data_i,

  output logic                         rob_wb_valid_o,
  output logic [ROB_DEPTHLOG2-1:0]     rob_wb_idx_o,
  output muldiv_pkg::word_t            rob_wb_result_o,
  output muldiv_pkg::reg_idx_t         rob_wb_dest_o,
  output logic                         rob_wb_dest_valid_o
);
  import muldiv_pkg::*;

  logic                     stall;
  logic                     no_dest;
  word_t                    result;
  muldiv_op_t               unit_op;
  word_t                    a_sel;
  word_t                    b_sel;

  // Issue register
  logic                     valid_r;
  logic                     dest_valid_r;
  logic                     a_fwd_r;
  logic                     b_fwd_r;
  muldiv_op_t               op_r;
  reg_idx_t                 dest_r;
  word_t                    a_r;
  word_t                    b_r;
  logic [ROB_DEPTHLOG2-1:0] slot_r;
  logic [ROB_DEPTHLOG2-1:0] a_fwd_slot_r;
  logic [ROB_DEPTHLOG2-1:0] b_fwd_slot_r;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_r      <= 1'b0;
      dest_valid_r <= 1'b0;
      a_fwd_r      <= 1'b0;
      b_fwd_r      <= 1'b0;
    end else if (ready_o) begin
      valid_r      <= inst_valid_i;
      dest_valid_r <= dest_valid_i;
      a_fwd_r      <= a_fwd_i;
      b_fwd_r      <= b_fwd_i;
    end
  end

  always_ff @(posedge clock) begin
    if (ready_o) begin
      op_r         <= op_i;
      dest_r       <= dest_reg_i;
      a_r          <= a_i;
      b_r          <= b_i;
      slot_r       <= rob_slot_i;
      a_fwd_slot_r <= a_fwd_slot_i;
      b_fwd_slot_r <= b_fwd_slot_i;
    end
  end

  // Operand select from the result file or the captured value
  assign a_lookup_idx_o = a_fwd_slot_r;
  assign b_lookup_idx_o = b_fwd_slot_r;
  assign a_sel          = a_fwd_r ? a_fwd_data_i : a_r;
  assign b_sel          = b_fwd_r ? b_fwd_data_i : b_r;
  assign unit_op        = valid_r ? op_r : OP_NONE;

  assign ready_o             = ~stall;
  assign rob_wb_valid_o      = valid_r & ready_o;
  assign rob_wb_idx_o        = slot_r;
  assign rob_wb_result_o     = result;
  assign rob_wb_dest_o       = dest_r;
  assign rob_wb_dest_valid_o = dest_valid_r & ~no_dest;

  muldiv_unit u_muldiv_unit (
    .clock     (clock),
    .reset_n   (reset_n),
    .op_i      (unit_op),
    .a_i       (a_sel),
    .b_i       (b_sel),
    .result_o  (result),
    .no_dest_o (no_dest),
    .stall_o   (stall)
  );

endmodule

`default_nettype wire

// ==== src/muldiv_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
  input  wire                          clock,
  input  wire                          reset_n,
  input  wire muldiv_pkg::muldiv_op_t  op_i,
  input  wire muldiv_pkg::word_t       a_i,
  input  wire muldiv_pkg::word_t       b_i,
  output muldiv_pkg::word_t            result_o,
  output logic                         no_dest_o,
  output logic                         stall_o
);
  import muldiv_pkg::*;

  mdu_state_t  state;
  logic [4:0]  count;
  word_t       hi;
  word_t       lo;

  // Iteration payload
  word_t       opb;
  logic [63:0] acc;
  logic        neg_lo;
  logic        neg_hi;
  logic        div_zero;

  logic        is_mul;
  logic        is_div;
  logic        is_signed;
  word_t       mag_a;
  word_t       mag_b;
  logic [32:0] mul_sum;
  logic [32:0] div_trial;
  logic [32:0] div_sub;
  logic        div_ge;
  logic [63:0] acc_next;
  logic [63:0] prod_final;
  word_t       quo_final;
  word_t       rem_final;

  assign is_mul    = (op_i == OP_MULT) || (op_i == OP_MULTU);
  assign is_div    = (op_i == OP_DIV) || (op_i == OP_DIVU);
  assign is_signed = (op_i == OP_MULT) || (op_i == OP_DIV);
  assign mag_a     = (is_signed && a_i[31]) ? -a_i : a_i;
  assign mag_b     = (is_signed && b_i[31]) ? -b_i : b_i;

  // ====================
  // One iteration step
  // ====================

  // acc holds {partial product, multiplier} or {remainder, dividend/quotient}
  always_comb begin
    mul_sum   = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opb} : 33'd0);
    div_trial = {acc[63:32], acc[31]};
    div_sub   = div_trial - {1'b0, opb};
    div_ge    = div_trial >= {1'b0, opb};
    if (state == DIV_RUN) begin
      if (div_ge) begin
        acc_next = {div_sub[31:0], acc[30:0], 1'b1};
      end else begin
        acc_next = {div_trial[31:0], acc[30:0], 1'b0};
      end
    end else begin
      acc_next = {mul_sum, acc[31:1]};
    end
  end

  // Sign fixup on the last step, remainder follows the dividend
  assign prod_final = neg_lo ? -acc_next : acc_next;
  assign rem_final  = neg_hi ? -acc_next[63:32] : acc_next[63:32];
  assign quo_final  = div_zero ? '1 : (neg_lo ? -acc_next[31:0] : acc_next[31:0]);

  // ====================
  // Control and HI/LO
  // ====================

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
      count <= '0;
      hi    <= '0;
      lo    <= '0;
    end else begin
      case (state)
        IDLE: begin
          count <= '0;
          if (is_mul) begin
            state <= MUL_RUN;
          end else if (is_div) begin
            state <= DIV_RUN;
          end
          if (op_i == OP_MTHI) hi <= a_i;
          if (op_i == OP_MTLO) lo <= a_i;
        end
        MUL_RUN, DIV_RUN: begin
          count <= count + 5'd1;
          if (count == 5'd31) begin
            state <= DONE;
            if (state == MUL_RUN) begin
              {hi, lo} <= prod_final;
            end else begin
              hi <= rem_final;
              lo <= quo_final;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && (is_mul || is_div)) begin
      opb      <= mag_b;
      acc      <= {32'd0, mag_a};
      neg_lo   <= is_signed & (a_i[31] ^ b_i[31]);
      neg_hi   <= is_signed & a_i[31];
      div_zero <= (b_i == '0);
    end else if (state == MUL_RUN || state == DIV_RUN) begin
      acc <= acc_next;
    end
  end

  assign stall_o   = (state == MUL_RUN) || (state == DIV_RUN) ||
                     ((state == IDLE) && (is_mul || is_div));
  assign result_o  = (op_i == OP_MFHI) ? hi : lo;
  assign no_dest_o = !((op_i == OP_MFHI) || (op_i == OP_MFLO));

endmodule

`default_nettype wire

// ==== src/muldiv_pkg.sv ====
`default_nettype none

package muldiv_pkg;

  // ====================
  // Data widths
  // ====================

  // Operands, results and the HI/LO pair
  typedef logic [31:0] word_t;

  // Architectural destination register number
  typedef logic [4:0] reg_idx_t;

  // ====================
  // Operation codes
  // ====================

  typedef enum logic [3:0] {
    OP_NONE  = 4'd0,
    OP_MULT  = 4'd1,
    OP_MULTU = 4'd2,
    OP_DIV   = 4'd3,
    OP_DIVU  = 4'd4,
    OP_MFHI  = 4'd5,
    OP_MFLO  = 4'd6,
    OP_MTHI  = 4'd7,
    OP_MTLO  = 4'd8
  } muldiv_op_t;

  // Iterative multiply/divide FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    MUL_RUN = 2'd1,
    DIV_RUN = 2'd2,
    DONE    = 2'd3
  } mdu_state_t;

endpackage

`default_nettype wire
